// ==== Bender.yml ====
package:
  name: timed_mixer

sources:
  # The control package refers to the data package
  - verilog/mixer_data_pkg.sv
  - verilog/mixer_cfg_pkg.sv
  - verilog/sample_clock.sv
  - verilog/timed_cmd_ctrl.sv
  - verilog/phase_nco.sv
  - verilog/iq_rotate_scale.sv
  - verilog/credit_egress.sv
  - verilog/timed_mixer.sv
  - target: test
    files:
      - sim/timed_mixer_tb.sv

// ==== project.f ====
verilog/mixer_data_pkg.sv
verilog/mixer_cfg_pkg.sv
verilog/sample_clock.sv
verilog/timed_cmd_ctrl.sv
verilog/phase_nco.sv
verilog/iq_rotate_scale.sv
verilog/credit_egress.sv
verilog/timed_mixer.sv
sim/timed_mixer_tb.sv

// ==== sim/timed_mixer_tb.sv ====
//####################################################################
// Trace driven testbench, run from the project root so the trace
// path resolves. Expected beats come from the trace, the late, dropped
// and arm counts below must match the trace contents.
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module timed_mixer_tb;

  localparam string TRACE_FILE      = "sim/timed_mixer_trace.txt";
  localparam int    CYCLES_PER_LINE = 40;
  localparam int    CYCLE_MARGIN    = 200;
  localparam int    RESET_CYCLES    = 16;
  localparam int    EXP_LATE        = 1;
  localparam int    EXP_DROPPED     = 1;
  localparam int    EXP_ARMED       = 2;

  typedef enum logic [1:0] {OP_SET, OP_IN, OP_CRED} op_kind_t;

  // One replayable trace line
  typedef struct packed {
    op_kind_t                     kind;
    mixer_cfg_pkg::set_cmd_t      cmd;
    mixer_data_pkg::sample_beat_t beat;
    logic [31:0]                  count;
  } trace_op_t;

  logic                         clk;
  logic                         rst;
  mixer_data_pkg::sample_beat_t in_beat;
  logic                         in_valid;
  logic                         in_credit;
  mixer_cfg_pkg::set_cmd_t      set_cmd;
  logic                         out_credit;
  mixer_data_pkg::sample_beat_t out_beat;
  logic                         out_valid;
  mixer_cfg_pkg::cmd_status_t   status;

  trace_op_t                    ops[$];
  mixer_data_pkg::sample_beat_t exp_q[$];
  logic [31:0]                  lcg_state;
  int                           cycle_cnt;
  int                           cycle_limit;
  int                           sent_cnt;
  int                           returned_cnt;
  int                           granted_cnt;
  int                           received_cnt;
  int                           late_cnt;
  int                           dropped_cnt;
  int                           armed_cnt;
  logic                         armed_prev;

  timed_mixer i_timed_mixer (
    .clk          (clk),
    .i_rst        (rst),
    .i_in_beat    (in_beat),
    .i_in_valid   (in_valid),
    .o_in_credit  (in_credit),
    .i_set        (set_cmd),
    .i_out_credit (out_credit),
    .o_out_beat   (out_beat),
    .o_out_valid  (out_valid),
    .o_status     (status)
  );

  always #2 clk = ~clk;

  task automatic check_value(input logic signed [63:0] got,
                             input logic signed [63:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upstream credits still held by the testbench
  function automatic int credits_held();
    return mixer_data_pkg::EGRESS_DEPTH - (sent_cnt - returned_cnt);
  endfunction

  task automatic load_trace();
    int                           fd;
    int                           n;
    int                           need;
    int                           line_cnt;
    int                           a;
    int                           b;
    int                           c;
    int                           d;
    longint                       t;
    logic [31:0]                  data;
    string                        line;
    string                        kind;
    trace_op_t                    op;
    mixer_data_pkg::sample_beat_t beat;
    line_cnt = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the trace file %s", TRACE_FILE);
      $display("Some tests failed");
      $fatal(1);
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%s", kind);
      if (n == 1 && kind.substr(0, 0) != "#") begin
        op = '0;
        beat = '0;
        line_cnt++;
        if (kind == "SET") begin
          n = $sscanf(line, "%s %d %h %d %d", kind, a, data, c, t);
          need = 5;
          op.kind = OP_SET;
          op.cmd.stb = 1'b1;
          op.cmd.addr = a[7:0];
          op.cmd.data.phase_inc = data;
          op.cmd.has_time = c[0];
          op.cmd.timestamp = t;
        end else if (kind == "IN" || kind == "EXP") begin
          n = $sscanf(line, "%s %d %d %d %d %d", kind, a, b, c, d, t);
          need = 6;
          beat.iq.i = a[15:0];
          beat.iq.q = b[15:0];
          beat.sof = c[0];
          beat.eof = d[0];
          beat.timestamp = t;
          op.kind = OP_IN;
          op.beat = beat;
        end else if (kind == "CRED") begin
          n = $sscanf(line, "%s %d", kind, a);
          need = 2;
          op.kind = OP_CRED;
          op.count = a;
        end else begin
          need = -1;
        end
        if (n != need) begin
          $display("Trace line %0d could not be read: %s", line_cnt, line);
          $display("Some tests failed");
          $fatal(1);
        end else if (kind == "EXP") begin
          exp_q.push_back(beat);
        end else begin
          ops.push_back(op);
        end
      end
    end
    $fclose(fd);
    cycle_limit = CYCLES_PER_LINE * line_cnt + CYCLE_MARGIN;
  endtask

  task automatic drive_set(input mixer_cfg_pkg::set_cmd_t cmd);
    set_cmd = cmd;
    @(posedge clk);
    #0.5;
    set_cmd = '0;
  endtask

  // Sends only while an upstream credit is held
  task automatic drive_beat(input mixer_data_pkg::sample_beat_t beat);
    while (credits_held() == 0) begin
      @(posedge clk);
      #0.5;
    end
    in_beat = beat;
    in_valid = 1'b1;
    sent_cnt++;
    @(posedge clk);
    #0.5;
    in_valid = 1'b0;
  endtask

  task automatic grant_credits(input int n);
    logic [31:0] rnd;
    for (int k = 0; k < n; k++) begin
      rnd = next_random();
      repeat (rnd[31:30]) begin
        @(posedge clk);
        #0.5;
      end
      out_credit = 1'b1;
      granted_cnt++;
      @(posedge clk);
      #0.5;
      out_credit = 1'b0;
    end
  endtask

  task automatic check_output();
    mixer_data_pkg::sample_beat_t exp;
    check_value(received_cnt < granted_cnt, 1, "beat sent without an output credit");
    check_value(exp_q.size() > 0, 1, "output beat with no expected entry");
    exp = exp_q.pop_front();
    check_value(out_beat.iq.i, exp.iq.i, $sformatf("beat %0d i", received_cnt));
    check_value(out_beat.iq.q, exp.iq.q, $sformatf("beat %0d q", received_cnt));
    check_value(out_beat.sof, exp.sof, $sformatf("beat %0d sof", received_cnt));
    check_value(out_beat.eof, exp.eof, $sformatf("beat %0d eof", received_cnt));
    if (exp.sof) begin
      check_value(out_beat.timestamp, exp.timestamp,
                  $sformatf("beat %0d timestamp", received_cnt));
    end
    received_cnt++;
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $fatal(1);
    end
  end

  // Output side and status monitor
  always @(posedge clk) begin
    if (!rst) begin
      if (in_credit) begin
        check_value(returned_cnt < sent_cnt, 1, "input credit without a sent beat");
        returned_cnt++;
      end
      if (status.late) begin
        late_cnt++;
      end
      if (status.dropped) begin
        dropped_cnt++;
      end
      // Each timed command that is taken raises armed once
      if (status.armed && !armed_prev) begin
        armed_cnt++;
      end
      armed_prev = status.armed;
      if (out_valid) begin
        check_output();
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    in_beat = '0;
    in_valid = 1'b0;
    set_cmd = '0;
    out_credit = 1'b0;
    lcg_state = 32'h84b4f5af;
    cycle_cnt = 0;
    cycle_limit = CYCLE_MARGIN;
    sent_cnt = 0;
    returned_cnt = 0;
    granted_cnt = 0;
    received_cnt = 0;
    late_cnt = 0;
    dropped_cnt = 0;
    armed_cnt = 0;
    armed_prev = 1'b0;
    load_trace();
    repeat (RESET_CYCLES) @(posedge clk);
    #0.5;
    rst = 1'b0;
    foreach (ops[k]) begin
      case (ops[k].kind)
        OP_SET:  drive_set(ops[k].cmd);
        OP_IN:   drive_beat(ops[k].beat);
        default: grant_credits(ops[k].count);
      endcase
    end
    // Drain, then watch a few more cycles for stray beats
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #0.5;
    end
    repeat (8) @(posedge clk);
    #0.5;
    check_value(credits_held(), mixer_data_pkg::EGRESS_DEPTH, "input credits after drain");
    check_value(late_cnt, EXP_LATE, "late pulse count");
    check_value(dropped_cnt, EXP_DROPPED, "dropped pulse count");
    check_value(armed_cnt, EXP_ARMED, "timed command arm count");
    check_value(status.armed, 0, "timed command still armed at the end");
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/timed_mixer_trace.txt ====
# Kinds: SET addr data(hex) has_time time | IN i q sof eof time | CRED count
# EXP i q sof eof time, decimal except SET data, time is checked only with sof
# Unity path, the 32767 table peak takes one lsb off positive values
IN 1000 -2000 1 0 100
IN -1 1 0 0 0
IN 32767 -32768 0 0 0
IN 0 0 0 1 0
EXP 999 -2000 1 0 100
EXP -1 0 0 0 0
EXP 32766 -32767 0 0 0
EXP 0 0 0 1 0
CRED 4
# Quarter turn per sample, gain drops to one half after four samples
SET 0 40000000 0 0
IN 1000 0 1 0 200
IN 1000 0 0 0 0
IN 1000 0 0 0 0
IN 1000 0 0 0 0
SET 1 00002000 0 0
IN 1004 0 0 0 0
IN 1003 0 0 0 0
IN 1004 0 0 0 0
IN 1003 0 0 1 0
EXP 0 999 1 0 200
EXP -1000 0 0 0 0
EXP 0 -1000 0 0 0
EXP 999 0 0 0 0
EXP 0 502 0 0 0
EXP -501 0 0 0 0
EXP 0 -502 0 0 0
EXP 501 0 0 1 0
CRED 8
# Timed quarter turn at 312, the sof at 311 reloads a count that would be at 310
SET 0 00000000 0 0
SET 1 00004000 0 0
SET 0 40000000 1 312
IN 500 300 1 0 308
IN 500 300 0 1 0
IN 500 300 1 0 311
IN 500 300 0 0 0
IN 500 300 0 1 0
EXP 499 299 1 0 308
EXP 499 299 0 1 0
EXP 499 299 1 0 311
EXP -300 499 0 0 0
EXP -500 -300 0 1 0
CRED 5
# Past time fires late on the next sample, the second timed write is dropped
SET 0 00000000 0 0
SET 0 40000000 1 50
SET 0 80000000 1 400
IN 200 -100 1 0 320
IN 200 -100 0 0 0
IN 200 -100 0 1 0
IN 200 -100 1 1 400
EXP -100 -200 1 0 320
EXP 199 -100 0 0 0
EXP 99 199 0 1 0
EXP -200 99 1 1 400
CRED 4
# Gain 3.99 saturates full scale input, phase held at a half turn
SET 0 00000000 0 0
SET 1 0000ff5c 0 0
IN 32767 -32768 1 0 600
IN 100 -50 0 0 0
IN -20000 20000 0 1 0
EXP -32768 32767 1 0 600
EXP -399 196 0 0 0
EXP 32767 -32768 0 1 0
CRED 3
# Output credits withheld until the egress FIFO holds eight beats
SET 1 00004000 0 0
IN 10 -10 1 0 700
IN 20 -20 0 0 0
IN 30 -30 0 0 0
IN 40 -40 0 0 0
IN 50 -50 0 0 0
IN 60 -60 0 0 0
IN 70 -70 0 0 0
IN 80 -80 0 1 0
EXP -10 9 1 0 700
EXP -20 19 0 0 0
EXP -30 29 0 0 0
EXP -40 39 0 0 0
EXP -50 49 0 0 0
EXP -60 59 0 0 0
EXP -70 69 0 0 0
EXP -80 79 0 1 0
CRED 8

// ==== verilog/credit_egress.sv ====
//####################################################################
// Egress FIFO that sends only against downstream credits.
// Each departing beat returns one credit to the upstream side,
// which is what keeps this FIFO from overflowing.
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module credit_egress (
  input  wire                                clk,
  input  wire                                i_rst,
  input  wire mixer_data_pkg::sample_beat_t  i_beat,
  input  wire                                i_valid,
  input  wire                                i_out_credit,
  output mixer_data_pkg::sample_beat_t       o_out_beat,
  output logic                               o_out_valid,
  output logic                               o_in_credit
);

  mixer_data_pkg::sample_beat_t          mem [mixer_data_pkg::EGRESS_DEPTH];
  logic [mixer_data_pkg::EGRESS_AW-1:0]  wr_ptr;
  logic [mixer_data_pkg::EGRESS_AW-1:0]  rd_ptr;
  logic [mixer_data_pkg::EGRESS_AW:0]    fill_q;
  logic [mixer_data_pkg::CREDIT_W-1:0]   credit_q;
  logic                                  send;

  assign send = (credit_q != '0) && (fill_q != '0);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fill_q      <= '0;
      credit_q    <= '0;
      o_out_valid <= 1'b0;
      o_in_credit <= 1'b0;
    end else begin
      o_out_valid <= send;
      o_in_credit <= send;
      if (i_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_valid, send})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
      // Credit in the same cycle as a send cancels out
      case ({i_out_credit, send})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      mem[wr_ptr] <= i_beat;
    end
    if (send) begin
      o_out_beat <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/iq_rotate_scale.sv ====
//####################################################################
// Complex rotate, gain and saturate, four stages from sample input.
// The gain is captured with each sample, so a change affects only
// samples accepted after it.
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module iq_rotate_scale (
  input  wire                                    clk,
  input  wire                                    i_rst,
  input  wire                                    i_valid,
  input  wire mixer_data_pkg::sample_beat_t      i_beat,
  input  wire signed [mixer_data_pkg::IQ_W-1:0]  i_cos,
  input  wire signed [mixer_data_pkg::IQ_W-1:0]  i_sin,
  input  wire [mixer_data_pkg::GAIN_W-1:0]       i_gain,
  output mixer_data_pkg::sample_beat_t           o_beat,
  output logic                                   o_valid
);

  // Round half up over the gain fraction, then clip to 16 bits
  function automatic logic signed [mixer_data_pkg::IQ_W-1:0] round_clip(
    input logic signed [mixer_data_pkg::SCALE_W-1:0] v
  );
    logic signed [mixer_data_pkg::SCALE_W-1:0] half_lsb;
    logic signed [mixer_data_pkg::SCALE_W-1:0] pos_lim;
    logic signed [mixer_data_pkg::SCALE_W-1:0] neg_lim;
    logic signed [mixer_data_pkg::SCALE_W-1:0] r;
    half_lsb = 1 <<< (mixer_data_pkg::GAIN_FRAC - 1);
    pos_lim  = (1 <<< (mixer_data_pkg::IQ_W - 1)) - 1;
    neg_lim  = -(1 <<< (mixer_data_pkg::IQ_W - 1));
    r = (v + half_lsb) >>> mixer_data_pkg::GAIN_FRAC;
    if (r > pos_lim) begin
      return pos_lim[mixer_data_pkg::IQ_W-1:0];
    end else if (r < neg_lim) begin
      return neg_lim[mixer_data_pkg::IQ_W-1:0];
    end
    return r[mixer_data_pkg::IQ_W-1:0];
  endfunction

  logic [mixer_data_pkg::PIPE_LAT-1:0]         vld_q;
  mixer_data_pkg::sample_beat_t                s1_beat;
  mixer_data_pkg::sample_beat_t                s2_beat;
  mixer_data_pkg::sample_beat_t                s3_beat;
  logic [mixer_data_pkg::GAIN_W-1:0]           s1_gain;
  logic [mixer_data_pkg::GAIN_W-1:0]           s2_gain;
  logic signed [2*mixer_data_pkg::IQ_W:0]      rot_i;
  logic signed [2*mixer_data_pkg::IQ_W:0]      rot_q;
  logic signed [mixer_data_pkg::ROT_W-1:0]     s2_i;
  logic signed [mixer_data_pkg::ROT_W-1:0]     s2_q;
  logic signed [mixer_data_pkg::SCALE_W-1:0]   scl_i;
  logic signed [mixer_data_pkg::SCALE_W-1:0]   scl_q;
  logic signed [mixer_data_pkg::SCALE_W-1:0]   s3_i;
  logic signed [mixer_data_pkg::SCALE_W-1:0]   s3_q;

  // Positive phase turns counter-clockwise
  assign rot_i = s1_beat.iq.i * i_cos - s1_beat.iq.q * i_sin;
  assign rot_q = s1_beat.iq.i * i_sin + s1_beat.iq.q * i_cos;

  assign scl_i = s2_i * $signed({1'b0, s2_gain});
  assign scl_q = s2_q * $signed({1'b0, s2_gain});

  assign o_valid = vld_q[mixer_data_pkg::PIPE_LAT-1];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[mixer_data_pkg::PIPE_LAT-2:0], i_valid};
    end
  end

  always_ff @(posedge clk) begin
    // Wait one cycle for the phasor of this sample
    if (i_valid) begin
      s1_beat <= i_beat;
      s1_gain <= i_gain;
    end
    // Rotate and drop the table fraction bits
    if (vld_q[0]) begin
      s2_beat <= s1_beat;
      s2_gain <= s1_gain;
      s2_i    <= rot_i[2*mixer_data_pkg::IQ_W:mixer_data_pkg::COS_FRAC];
      s2_q    <= rot_q[2*mixer_data_pkg::IQ_W:mixer_data_pkg::COS_FRAC];
    end
    if (vld_q[1]) begin
      s3_beat <= s2_beat;
      s3_i    <= scl_i;
      s3_q    <= scl_q;
    end
    // Flags and timestamp pass through, only iq is replaced
    if (vld_q[2]) begin
      o_beat      <= s3_beat;
      o_beat.iq.i <= round_clip(s3_i);
      o_beat.iq.q <= round_clip(s3_q);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mixer_cfg_pkg.sv ====
//####################################################################
// Settings bus, command and status types for the control side.
// The data word is read as a phase increment or a gain by address.
//####################################################################
`default_nettype none

package mixer_cfg_pkg;

  localparam int SR_AW = 8;
  localparam int SR_DW = 32;

  // Register addresses
  localparam logic [SR_AW-1:0] SR_FREQ = 8'd0;
  localparam logic [SR_AW-1:0] SR_GAIN = 8'd1;

  // Unity gain, 1.0 in the 14 fraction bit format
  localparam logic [mixer_data_pkg::GAIN_W-1:0] GAIN_UNITY =
    {{(mixer_data_pkg::GAIN_W - mixer_data_pkg::GAIN_FRAC - 1){1'b0}},
     1'b1, {mixer_data_pkg::GAIN_FRAC{1'b0}}};

  typedef struct packed {
    logic [SR_DW-mixer_data_pkg::GAIN_W-1:0] pad;
    logic [mixer_data_pkg::GAIN_W-1:0]       gain;
  } gain_word_t;

  typedef union packed {
    logic [mixer_data_pkg::PHASE_W-1:0] phase_inc;
    gain_word_t                         gain_word;
  } cfg_word_u;

  typedef struct packed {
    logic                              stb;
    logic [SR_AW-1:0]                  addr;
    cfg_word_u                         data;
    logic                              has_time;
    logic [mixer_data_pkg::TIME_W-1:0] timestamp;
  } set_cmd_t;

  typedef enum logic {CMD_IDLE, CMD_ARMED} cmd_state_t;

  typedef struct packed {
    logic armed;
    logic dropped;
    logic late;
  } cmd_status_t;

endpackage

`default_nettype wire

// ==== verilog/mixer_data_pkg.sv ====
//####################################################################
// Data side widths, fixed point formats and the sample beat type.
// The egress depth must be a power of two.
//####################################################################
`default_nettype none

package mixer_data_pkg;

  // Sample, oscillator, gain and timestamp widths
  localparam int IQ_W     = 16;
  localparam int PHASE_W  = 32;
  localparam int LUT_BITS = 8;
  localparam int GAIN_W   = 18;
  localparam int TIME_W   = 64;

  // Table values carry 15 fraction bits, gain carries 14
  localparam int COS_FRAC  = 15;
  localparam int GAIN_FRAC = 14;
  localparam int ROT_W     = 2 * IQ_W + 1 - COS_FRAC;
  localparam int SCALE_W   = ROT_W + GAIN_W + 1;

  localparam int PIPE_LAT     = 4;
  localparam int EGRESS_DEPTH = 8;
  localparam int EGRESS_AW    = $clog2(EGRESS_DEPTH);
  localparam int CREDIT_W     = 16;

  typedef struct packed {
    logic signed [IQ_W-1:0] i;
    logic signed [IQ_W-1:0] q;
  } iq_t;

  // timestamp is meaningful only when sof is set
  typedef struct packed {
    iq_t               iq;
    logic              sof;
    logic              eof;
    logic [TIME_W-1:0] timestamp;
  } sample_beat_t;

endpackage

`default_nettype wire

// ==== verilog/phase_nco.sv ====
//####################################################################
// Phase accumulator with a 256 entry cosine and sine table.
// The table is built by a real valued constant function, so the
// tool must support $cos and $sin during elaboration.
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module phase_nco (
  input  wire                                        clk,
  input  wire                                        i_rst,
  input  wire                                        i_valid,
  input  wire [mixer_data_pkg::PHASE_W-1:0]          i_phase_inc,
  output logic signed [mixer_data_pkg::IQ_W-1:0]     o_cos,
  output logic signed [mixer_data_pkg::IQ_W-1:0]     o_sin,
  output logic                                       o_valid
);

  typedef logic signed [mixer_data_pkg::IQ_W-1:0] lut_entry_t;
  typedef lut_entry_t [(1 << mixer_data_pkg::LUT_BITS)-1:0] lut_t;

  // Entry k holds round(32767 * cos(2*pi*k/256)) or the sine
  function automatic lut_t build_lut(input bit sin_table);
    lut_t tbl;
    real  ang;
    real  val;
    for (int k = 0; k < (1 << mixer_data_pkg::LUT_BITS); k++) begin
      ang = 6.283185307179586 * k / (1 << mixer_data_pkg::LUT_BITS);
      val = 32767.0 * (sin_table ? $sin(ang) : $cos(ang));
      tbl[k] = lut_entry_t'(int'(val));
    end
    return tbl;
  endfunction

  localparam lut_t COS_LUT = build_lut(1'b0);
  localparam lut_t SIN_LUT = build_lut(1'b1);

  logic [mixer_data_pkg::PHASE_W-1:0]  acc_q;
  logic [mixer_data_pkg::PHASE_W-1:0]  next_phase;
  logic [mixer_data_pkg::LUT_BITS-1:0] lut_idx;

  // Look up the phase after this sample's step
  assign next_phase = acc_q + i_phase_inc;
  assign lut_idx    = next_phase[mixer_data_pkg::PHASE_W-1 -: mixer_data_pkg::LUT_BITS];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      acc_q   <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        acc_q <= next_phase;
      end
    end
  end

  // Phasor holds until the next accepted sample
  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_cos <= COS_LUT[lut_idx];
      o_sin <= SIN_LUT[lut_idx];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sample_clock.sv ====
//####################################################################
// Running timestamp of the input stream, one tick per sample.
// A beat without sof before the first packet counts from zero.
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module sample_clock (
  input  wire                                clk,
  input  wire                                i_rst,
  input  wire                                i_valid,
  input  wire mixer_data_pkg::sample_beat_t  i_beat,
  output logic [mixer_data_pkg::TIME_W-1:0]  o_time
);

  logic [mixer_data_pkg::TIME_W-1:0] time_q;
  logic                              load;

  // Start of packet carries its own timestamp
  assign load = i_valid && i_beat.sof;

  // Time of the sample being accepted right now
  assign o_time = load ? i_beat.timestamp : time_q;

  // Holds the time of the next expected sample
  always_ff @(posedge clk) begin
    if (i_rst) begin
      time_q <= '0;
    end else if (i_valid) begin
      time_q <= o_time + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/timed_cmd_ctrl.sv ====
//####################################################################
// Settings decode with one pending timed frequency command.
// Gain writes always apply at once, their time field is ignored.
// A command whose time has passed fires on the next sample.
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module timed_cmd_ctrl (
  input  wire                                  clk,
  input  wire                                  i_rst,
  input  wire mixer_cfg_pkg::set_cmd_t         i_set,
  input  wire                                  i_valid,
  input  wire [mixer_data_pkg::TIME_W-1:0]     i_time,
  output logic [mixer_data_pkg::PHASE_W-1:0]   o_phase_inc,
  output logic [mixer_data_pkg::GAIN_W-1:0]    o_gain,
  output mixer_cfg_pkg::cmd_status_t           o_status
);

  mixer_cfg_pkg::cmd_state_t         state_q;
  logic [mixer_data_pkg::PHASE_W-1:0] inc_q;
  logic [mixer_data_pkg::PHASE_W-1:0] cmd_inc_q;
  logic [mixer_data_pkg::TIME_W-1:0]  cmd_time_q;
  logic [mixer_data_pkg::GAIN_W-1:0]  gain_q;
  logic                               dropped_q;
  logic                               late_q;
  logic                               armed;
  logic                               freq_wr;
  logic                               gain_wr;
  logic                               timed_wr;
  logic                               fire;

  assign armed    = (state_q == mixer_cfg_pkg::CMD_ARMED);
  assign freq_wr  = i_set.stb && (i_set.addr == mixer_cfg_pkg::SR_FREQ);
  assign gain_wr  = i_set.stb && (i_set.addr == mixer_cfg_pkg::SR_GAIN);
  assign timed_wr = freq_wr && i_set.has_time;

  // Fires on the matching sample, or the first one after a missed time
  assign fire = armed && i_valid && (i_time >= cmd_time_q);

  // The firing sample already uses the new increment
  assign o_phase_inc = fire ? cmd_inc_q : inc_q;
  assign o_gain      = gain_q;
  assign o_status    = '{armed: armed, dropped: dropped_q, late: late_q};

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q   <= mixer_cfg_pkg::CMD_IDLE;
      inc_q     <= '0;
      gain_q    <= mixer_cfg_pkg::GAIN_UNITY;
      dropped_q <= 1'b0;
      late_q    <= 1'b0;
    end else begin
      dropped_q <= timed_wr && armed;
      late_q    <= fire && (i_time != cmd_time_q);
      case (state_q)
        mixer_cfg_pkg::CMD_IDLE: begin
          if (timed_wr) begin
            state_q <= mixer_cfg_pkg::CMD_ARMED;
          end
        end
        default: begin
          if (fire) begin
            inc_q   <= cmd_inc_q;
            state_q <= mixer_cfg_pkg::CMD_IDLE;
          end
        end
      endcase
      // An immediate write in the firing cycle is the newer value
      if (freq_wr && !i_set.has_time) begin
        inc_q <= i_set.data.phase_inc;
      end
      if (gain_wr) begin
        gain_q <= i_set.data.gain_word.gain;
      end
    end
  end

  // Pending command payload
  always_ff @(posedge clk) begin
    if (timed_wr && !armed) begin
      cmd_inc_q  <= i_set.data.phase_inc;
      cmd_time_q <= i_set.timestamp;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/timed_mixer.sv ====
//####################################################################
// Timed frequency shifter for complex baseband samples.
// Upstream starts with EGRESS_DEPTH credits and never sends without
// one, the DUT starts with no output credits after reset.
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module timed_mixer (
  input  wire                                clk,
  input  wire                                i_rst,
  input  wire mixer_data_pkg::sample_beat_t  i_in_beat,
  input  wire                                i_in_valid,
  output logic                               o_in_credit,
  input  wire mixer_cfg_pkg::set_cmd_t       i_set,
  input  wire                                i_out_credit,
  output mixer_data_pkg::sample_beat_t       o_out_beat,
  output logic                               o_out_valid,
  output mixer_cfg_pkg::cmd_status_t         o_status
);

  logic [mixer_data_pkg::TIME_W-1:0]      sample_time;
  logic [mixer_data_pkg::PHASE_W-1:0]     phase_inc;
  logic [mixer_data_pkg::GAIN_W-1:0]      gain;
  logic signed [mixer_data_pkg::IQ_W-1:0] nco_cos;
  logic signed [mixer_data_pkg::IQ_W-1:0] nco_sin;
  mixer_data_pkg::sample_beat_t           mix_beat;
  logic                                   mix_valid;

  sample_clock i_sample_clock (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (i_in_valid),
    .i_beat  (i_in_beat),
    .o_time  (sample_time)
  );

  timed_cmd_ctrl i_timed_cmd_ctrl (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_set       (i_set),
    .i_valid     (i_in_valid),
    .i_time      (sample_time),
    .o_phase_inc (phase_inc),
    .o_gain      (gain),
    .o_status    (o_status)
  );

  // Phasor validity matches the delayed sample inside the rotator
  phase_nco i_phase_nco (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_valid     (i_in_valid),
    .i_phase_inc (phase_inc),
    .o_cos       (nco_cos),
    .o_sin       (nco_sin),
    .o_valid     ()
  );

  iq_rotate_scale i_iq_rotate_scale (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (i_in_valid),
    .i_beat  (i_in_beat),
    .i_cos   (nco_cos),
    .i_sin   (nco_sin),
    .i_gain  (gain),
    .o_beat  (mix_beat),
    .o_valid (mix_valid)
  );

  credit_egress i_credit_egress (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_beat       (mix_beat),
    .i_valid      (mix_valid),
    .i_out_credit (i_out_credit),
    .o_out_beat   (o_out_beat),
    .o_out_valid  (o_out_valid),
    .o_in_credit  (o_in_credit)
  );

endmodule

`default_nettype wire
